// File: sources.f
hw/lsq_cfg_pkg.sv
hw/lsq_port_pkg.sv
hw/queue_ptrs.sv
hw/store_forward.sv
hw/store_queue.sv
hw/load_queue.sv
hw/lsq_top.sv
tb/lsq_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the load/store queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module lsq_tb -f sources.f -o lsq_sim
./obj_dir/lsq_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0

// File: tb/lsq_tb.sv
`timescale 1ns/10ps

module lsq_tb
  import lsq_cfg_pkg::*;
  import lsq_port_pkg::*;
();

  localparam int clk_period      = 100;
  localparam int reset_cycles    = 5;
  // Every stimulus task takes two cycles
  localparam int max_ops         = 48;
  localparam int watchdog_cycles = reset_cycles + 2 * max_ops + 20;

  localparam logic [addr_w-1:0] addr_a = 32'h40;
  localparam logic [addr_w-1:0] addr_b = 32'h80;
  localparam logic [addr_w-1:0] addr_c = 32'hc0;
  localparam logic [addr_w-1:0] addr_d = 32'h100;
  localparam logic [addr_w-1:0] addr_e = 32'h140;
  localparam logic [addr_w-1:0] addr_f = 32'h180;
  localparam logic [addr_w-1:0] addr_g = 32'h200;

  logic          clock;
  logic          reset;
  dispatch_t     dispatch;
  store_exec_t   store_exec;
  load_exec_t    load_exec;
  logic          retire_store;
  logic          retire_load;
  cache_rd_rsp_t cache_rd_rsp;
  logic          cache_wr_ready;
  logic          dispatch_ready;
  lsq_idx_t      sq_idx;
  lsq_idx_t      lq_idx;
  cache_rd_req_t cache_rd_req;
  cache_wr_req_t cache_wr_req;
  logic          load_accept;
  load_result_t  load_result;
  violation_t    violation;
  logic          store_retired;

  // Memory model, initial contents plus words written back by stores
  logic [data_w-1:0] fill    [0:255];
  logic [data_w-1:0] written [0:255];
  logic [255:0]      was_written;
  logic              rsp_enable;
  logic [31:0]       lcg_state;
  int                errors = 0;

  // Expected values, kept stable until the next task that owns them
  logic              chk_lq;
  logic              chk_sq;
  logic              chk_ready;
  logic              chk_fwd;
  logic              chk_wr;
  logic              exp_ready;
  logic              exp_accept;
  logic              exp_fwd;
  logic              exp_viol;
  logic              exp_retired;
  lsq_idx_t          exp_lq_idx;
  lsq_idx_t          exp_sq_idx;
  lsq_idx_t          exp_res_idx;
  lsq_idx_t          exp_viol_idx;
  lsq_idx_t          sq_tail_m;
  lsq_idx_t          lq_tail_m;
  logic [data_w-1:0] exp_data;
  logic [data_w-1:0] exp_wr_data;
  logic [addr_w-1:0] exp_wr_addr;
  logic [addr_w-1:0] exp_viol_pc;

  lsq_top u_dut (
    .clock          (clock),
    .reset          (reset),
    .dispatch       (dispatch),
    .store_exec     (store_exec),
    .load_exec      (load_exec),
    .retire_store   (retire_store),
    .retire_load    (retire_load),
    .cache_rd_rsp   (cache_rd_rsp),
    .cache_wr_ready (cache_wr_ready),
    .dispatch_ready (dispatch_ready),
    .sq_idx         (sq_idx),
    .lq_idx         (lq_idx),
    .cache_rd_req   (cache_rd_req),
    .cache_wr_req   (cache_wr_req),
    .load_accept    (load_accept),
    .load_result    (load_result),
    .violation      (violation),
    .store_retired  (store_retired)
  );

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [data_w-1:0] mem_word(input logic [addr_w-1:0] addr);
    return was_written[addr[10:3]] ? written[addr[10:3]] : fill[addr[10:3]];
  endfunction

  // Reads answer in the same cycle
  always_comb begin
    cache_rd_rsp.valid = cache_rd_req.rd_en & rsp_enable;
    cache_rd_rsp.data  = mem_word(cache_rd_req.addr);
  end

  always @(posedge clock) begin
    if (reset) begin
      was_written <= '0;
    end else if (cache_wr_req.wr_en && cache_wr_ready) begin
      was_written[cache_wr_req.addr[10:3]] <= 1'b1;
      written[cache_wr_req.addr[10:3]]     <= cache_wr_req.data;
    end
  end

  task automatic random_word(output logic [data_w-1:0] w);
    lcg_state = lcg_next(lcg_state);
    w[63:32]  = lcg_state;
    lcg_state = lcg_next(lcg_state);
    w[31:0]   = lcg_state;
  endtask

  task automatic log_mismatch(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    errors++;
    $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
  endtask

  task automatic log_failure(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic clear_inputs();
    dispatch     = '0;
    store_exec   = '0;
    load_exec    = '0;
    retire_store = 1'b0;
    retire_load  = 1'b0;
    chk_lq       = 1'b0;
    chk_sq       = 1'b0;
    chk_ready    = 1'b0;
    chk_fwd      = 1'b0;
    chk_wr       = 1'b0;
    exp_retired  = 1'b0;
  endtask

  task automatic dispatch_op(input mem_op_e op, input logic [addr_w-1:0] pc,
                             input logic ready, output lsq_idx_t idx);
    @(negedge clock);
    dispatch.valid = 1'b1;
    dispatch.op    = op;
    dispatch.pc    = pc;
    chk_ready      = 1'b1;
    exp_ready      = ready;
    if (op == mem_load) begin
      idx        = lq_tail_m;
      chk_lq     = ready;
      exp_lq_idx = lq_tail_m;
      if (ready)
        lq_tail_m = lq_tail_m + lsq_idx_t'(1);
    end else begin
      idx        = sq_tail_m;
      chk_sq     = ready;
      exp_sq_idx = sq_tail_m;
      if (ready)
        sq_tail_m = sq_tail_m + lsq_idx_t'(1);
    end
    @(negedge clock);
    clear_inputs();
  endtask

  task automatic exec_store(input lsq_idx_t idx, input logic [addr_w-1:0] addr,
                            input logic [data_w-1:0] data, input logic viol);
    @(negedge clock);
    store_exec.valid  = 1'b1;
    store_exec.sq_idx = idx;
    store_exec.addr   = addr;
    store_exec.data   = data;
    exp_viol          = viol;
    @(negedge clock);
    clear_inputs();
  endtask

  task automatic exec_load(input lsq_idx_t idx, input logic [addr_w-1:0] addr,
                           input logic fwd, input logic [data_w-1:0] data,
                           input logic accept);
    @(negedge clock);
    load_exec.valid  = 1'b1;
    load_exec.lq_idx = idx;
    load_exec.addr   = addr;
    chk_fwd          = fwd;
    exp_fwd          = fwd;
    exp_data         = data;
    exp_accept       = accept;
    exp_res_idx      = idx;
    @(negedge clock);
    clear_inputs();
  endtask

  task automatic retire_head(input logic ready, input logic [addr_w-1:0] addr,
                             input logic [data_w-1:0] data);
    @(negedge clock);
    retire_store   = 1'b1;
    cache_wr_ready = ready;
    chk_wr         = 1'b1;
    exp_retired    = ready;
    exp_wr_addr    = addr;
    exp_wr_data    = data;
    @(negedge clock);
    clear_inputs();
  endtask

  task automatic retire_oldest_load();
    @(negedge clock);
    retire_load = 1'b1;
    @(negedge clock);
    clear_inputs();
  endtask

  // Dispatch
  assert property (@(posedge clock) disable iff (reset) chk_lq |-> lq_idx == exp_lq_idx)
    else log_mismatch("lq_idx", 64'($sampled(lq_idx)), 64'(exp_lq_idx));
  assert property (@(posedge clock) disable iff (reset) chk_sq |-> sq_idx == exp_sq_idx)
    else log_mismatch("sq_idx", 64'($sampled(sq_idx)), 64'(exp_sq_idx));
  assert property (@(posedge clock) disable iff (reset)
    chk_ready |-> dispatch_ready == exp_ready)
    else log_mismatch("dispatch_ready", 64'($sampled(dispatch_ready)), 64'(exp_ready));

  // Load execute and result
  assert property (@(posedge clock) disable iff (reset) chk_fwd |-> !cache_rd_req.rd_en)
    else log_failure("cache read issued although a store should forward");
  assert property (@(posedge clock) disable iff (reset)
    load_exec.valid |-> load_accept == exp_accept)
    else log_mismatch("load_accept", 64'($sampled(load_accept)), 64'(exp_accept));
  assert property (@(posedge clock) disable iff (reset)
    load_exec.valid |=> load_result.valid == exp_accept)
    else log_mismatch("load_result.valid", 64'($sampled(load_result.valid)),
                      64'(exp_accept));
  assert property (@(posedge clock) disable iff (reset)
    load_exec.valid && exp_accept |=> load_result.lq_idx == exp_res_idx)
    else log_mismatch("load_result.lq_idx", 64'($sampled(load_result.lq_idx)),
                      64'(exp_res_idx));
  assert property (@(posedge clock) disable iff (reset)
    load_exec.valid && exp_accept |=> load_result.data == exp_data)
    else log_mismatch("load_result.data", $sampled(load_result.data), exp_data);
  assert property (@(posedge clock) disable iff (reset)
    load_exec.valid && exp_accept |=> load_result.forwarded == exp_fwd)
    else log_mismatch("load_result.forwarded", 64'($sampled(load_result.forwarded)),
                      64'(exp_fwd));

  // Store retire
  assert property (@(posedge clock) disable iff (reset) store_retired == exp_retired)
    else log_mismatch("store_retired", 64'($sampled(store_retired)), 64'(exp_retired));
  assert property (@(posedge clock) disable iff (reset) chk_wr |-> cache_wr_req.wr_en)
    else log_failure("no cache write during a store retire pulse");
  assert property (@(posedge clock) disable iff (reset)
    chk_wr |-> cache_wr_req.addr == exp_wr_addr)
    else log_mismatch("cache_wr_req.addr", 64'($sampled(cache_wr_req.addr)),
                      64'(exp_wr_addr));
  assert property (@(posedge clock) disable iff (reset)
    chk_wr |-> cache_wr_req.data == exp_wr_data)
    else log_mismatch("cache_wr_req.data", $sampled(cache_wr_req.data), exp_wr_data);

  // Memory order violations
  assert property (@(posedge clock) disable iff (reset)
    store_exec.valid |=> violation.valid == exp_viol)
    else log_mismatch("violation.valid", 64'($sampled(violation.valid)), 64'(exp_viol));
  assert property (@(posedge clock) disable iff (reset)
    store_exec.valid && exp_viol |=> violation.lq_idx == exp_viol_idx)
    else log_mismatch("violation.lq_idx", 64'($sampled(violation.lq_idx)),
                      64'(exp_viol_idx));
  assert property (@(posedge clock) disable iff (reset)
    store_exec.valid && exp_viol |=> violation.pc == exp_viol_pc)
    else log_mismatch("violation.pc", 64'($sampled(violation.pc)), 64'(exp_viol_pc));

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    lsq_idx_t          sq_a;
    lsq_idx_t          sq_b;
    lsq_idx_t          sq_c;
    lsq_idx_t          lq_a;
    lsq_idx_t          lq_b;
    lsq_idx_t          idx;
    logic [data_w-1:0] d0;
    logic [data_w-1:0] d1;
    logic [data_w-1:0] w;

    reset          = 1'b1;
    rsp_enable     = 1'b1;
    cache_wr_ready = 1'b1;
    lcg_state      = 32'h5a97;
    exp_accept     = 1'b0;
    exp_viol       = 1'b0;
    exp_fwd        = 1'b0;
    exp_data       = '0;
    sq_tail_m      = '0;
    lq_tail_m      = '0;
    clear_inputs();
    for (int i = 0; i < 256; i++) begin
      random_word(w);
      fill[8'(i)] = w;
    end
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b0;

    // Seven loads fill the load queue, an eighth stalls but a store fits
    for (int i = 0; i < lsq_depth - 1; i++) begin
      dispatch_op(mem_load, 32'h100 + 32'(4 * i), 1'b1, idx);
    end
    dispatch_op(mem_load, 32'h200, 1'b0, idx);
    dispatch_op(mem_store, 32'h204, 1'b1, sq_a);
    repeat (lsq_depth - 1) retire_oldest_load();

    // Two older stores to one address, the younger one forwards
    dispatch_op(mem_store, 32'h208, 1'b1, sq_b);
    random_word(d0);
    random_word(d1);
    exec_store(sq_a, addr_a, d0, 1'b0);
    exec_store(sq_b, addr_a, d1, 1'b0);
    dispatch_op(mem_load, 32'h20c, 1'b1, lq_a);
    exec_load(lq_a, addr_a, 1'b1, d1, 1'b1);

    // Matching store is younger than the load
    dispatch_op(mem_load, 32'h210, 1'b1, lq_b);
    dispatch_op(mem_store, 32'h214, 1'b1, sq_c);
    random_word(w);
    exec_store(sq_c, addr_b, w, 1'b0);
    exec_load(lq_b, addr_b, 1'b0, mem_word(addr_b), 1'b1);

    // Head store held back once, then written
    retire_head(1'b0, addr_a, d0);
    retire_head(1'b1, addr_a, d0);
    retire_head(1'b1, addr_a, d1);

    // Younger load completes before the older store executes
    retire_oldest_load();
    retire_oldest_load();
    dispatch_op(mem_store, 32'h300, 1'b1, sq_a);
    dispatch_op(mem_load, 32'h304, 1'b1, lq_a);
    exec_load(lq_a, addr_c, 1'b0, mem_word(addr_c), 1'b1);
    exp_viol_idx = lq_a;
    exp_viol_pc  = 32'h304;
    random_word(w);
    exec_store(sq_a, addr_c, w, 1'b1);

    // Load older than the store
    dispatch_op(mem_load, 32'h308, 1'b1, lq_b);
    dispatch_op(mem_store, 32'h30c, 1'b1, sq_b);
    exec_load(lq_b, addr_d, 1'b0, mem_word(addr_d), 1'b1);
    random_word(w);
    exec_store(sq_b, addr_d, w, 1'b0);

    // Younger load, different address
    dispatch_op(mem_store, 32'h310, 1'b1, sq_c);
    dispatch_op(mem_load, 32'h314, 1'b1, lq_a);
    exec_load(lq_a, addr_e, 1'b0, mem_word(addr_e), 1'b1);
    random_word(w);
    exec_store(sq_c, addr_f, w, 1'b0);

    // Cache does not answer, so the load retries
    dispatch_op(mem_load, 32'h318, 1'b1, lq_b);
    rsp_enable = 1'b0;
    exec_load(lq_b, addr_g, 1'b0, mem_word(addr_g), 1'b0);
    rsp_enable = 1'b1;
    exec_load(lq_b, addr_g, 1'b0, mem_word(addr_g), 1'b1);

    @(negedge clock);
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: hw/lsq_top.sv
`timescale 1ns/10ps

module lsq_top
  import lsq_cfg_pkg::*;
  import lsq_port_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  dispatch_t     dispatch,
  input  store_exec_t   store_exec,
  input  load_exec_t    load_exec,
  input  logic          retire_store,
  input  logic          retire_load,
  input  cache_rd_rsp_t cache_rd_rsp,
  input  logic          cache_wr_ready,
  output logic          dispatch_ready,
  output lsq_idx_t      sq_idx,
  output lsq_idx_t      lq_idx,
  output cache_rd_req_t cache_rd_req,
  output cache_wr_req_t cache_wr_req,
  output logic          load_accept,
  output load_result_t  load_result,
  output violation_t    violation,
  output logic          store_retired
);

  logic              sq_alloc;
  logic              lq_alloc;
  logic              sq_full;
  logic              lq_full;
  lsq_idx_t          sq_head;
  lsq_idx_t          fwd_limit;
  logic [addr_w-1:0] fwd_addr;
  logic              fwd_hit;
  logic [data_w-1:0] fwd_data;

  // Stall only on the queue this op needs
  always_comb begin
    case (dispatch.op)
      mem_load:  dispatch_ready = ~lq_full;
      mem_store: dispatch_ready = ~sq_full;
      default:   dispatch_ready = 1'b1;
    endcase
  end

  assign sq_alloc = dispatch.valid & dispatch_ready & (dispatch.op == mem_store);
  assign lq_alloc = dispatch.valid & dispatch_ready & (dispatch.op == mem_load);

  // Entries port stays open; violation search needs only the store head
  store_queue u_sq (
    .clock          (clock),
    .reset          (reset),
    .alloc          (sq_alloc),
    .store_exec     (store_exec),
    .retire_store   (retire_store),
    .cache_wr_ready (cache_wr_ready),
    .fwd_limit      (fwd_limit),
    .fwd_addr       (fwd_addr),
    .tail           (sq_idx),
    .head           (sq_head),
    .full           (sq_full),
    .entries        (),
    .fwd_hit        (fwd_hit),
    .fwd_data       (fwd_data),
    .cache_wr_req   (cache_wr_req),
    .store_retired  (store_retired)
  );

  load_queue u_lq (
    .clock        (clock),
    .reset        (reset),
    .alloc        (lq_alloc),
    .pc           (dispatch.pc),
    .sq_tail      (sq_idx),
    .sq_head      (sq_head),
    .load_exec    (load_exec),
    .store_exec   (store_exec),
    .retire_load  (retire_load),
    .fwd_hit      (fwd_hit),
    .fwd_data     (fwd_data),
    .cache_rd_rsp (cache_rd_rsp),
    .tail         (lq_idx),
    .full         (lq_full),
    .fwd_limit    (fwd_limit),
    .fwd_addr     (fwd_addr),
    .cache_rd_req (cache_rd_req),
    .load_accept  (load_accept),
    .load_result  (load_result),
    .violation    (violation)
  );

endmodule

// File: hw/load_queue.sv
`timescale 1ns/10ps

module load_queue
  import lsq_cfg_pkg::*;
  import lsq_port_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   alloc,
  input  logic    [addr_w-1:0]   pc,
  input  lsq_idx_t               sq_tail,
  input  lsq_idx_t               sq_head,
  input  load_exec_t             load_exec,
  input  store_exec_t            store_exec,
  input  logic                   retire_load,
  input  logic                   fwd_hit,
  input  logic    [data_w-1:0]   fwd_data,
  input  cache_rd_rsp_t          cache_rd_rsp,
  output lsq_idx_t               tail,
  output logic                   full,
  output lsq_idx_t               fwd_limit,
  output logic    [addr_w-1:0]   fwd_addr,
  output cache_rd_req_t          cache_rd_req,
  output logic                   load_accept,
  output load_result_t           load_result,
  output violation_t             violation
);

  lq_entry_t [lsq_depth-1:0] entries;
  lsq_idx_t                  head;
  logic                      viol_hit;
  lsq_idx_t                  viol_idx;

  queue_ptrs u_ptrs (
    .clock   (clock),
    .reset   (reset),
    .alloc   (alloc),
    .dealloc (retire_load),
    .head    (head),
    .tail    (tail),
    .full    (full)
  );

  // Forward search only looks at stores older than this load
  assign fwd_limit = entries[load_exec.lq_idx].sq_snap;
  assign fwd_addr  = load_exec.addr;

  always_comb begin
    cache_rd_req.rd_en = load_exec.valid & ~fwd_hit;
    cache_rd_req.addr  = load_exec.addr;
  end

  // Cache miss with no response means the load retries later
  assign load_accept = load_exec.valid & (fwd_hit | cache_rd_rsp.valid);

  // Oldest live load that already completed, is younger than the
  // executing store and read the same address
  always_comb begin
    lsq_idx_t idx;
    lsq_idx_t live;
    lsq_idx_t st_age;
    lsq_idx_t ld_age;

    viol_hit = 1'b0;
    viol_idx = '0;
    live     = tail - head;
    st_age   = store_exec.sq_idx - sq_head;

    for (int j = 0; j < lsq_depth; j++) begin
      idx    = head + lsq_idx_t'(j);
      ld_age = entries[idx].sq_snap - sq_head;
      if (!viol_hit && (j < int'(live)) && entries[idx].done &&
          (entries[idx].addr == store_exec.addr) && (st_age < ld_age)) begin
        viol_hit = 1'b1;
        viol_idx = idx;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      entries[tail].done    <= 1'b0;
      entries[tail].pc      <= pc;
      entries[tail].sq_snap <= sq_tail;
    end
    if (load_accept) begin
      entries[load_exec.lq_idx].done <= 1'b1;
      entries[load_exec.lq_idx].addr <= load_exec.addr;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      load_result.valid <= 1'b0;
      violation.valid   <= 1'b0;
    end else begin
      load_result.valid <= load_accept;
      violation.valid   <= store_exec.valid & viol_hit;
    end
  end

  always_ff @(posedge clock) begin
    load_result.lq_idx    <= load_exec.lq_idx;
    load_result.data      <= fwd_hit ? fwd_data : cache_rd_rsp.data;
    load_result.forwarded <= fwd_hit;
    violation.lq_idx      <= viol_idx;
    violation.pc          <= entries[viol_idx].pc;
  end

endmodule

// File: hw/store_queue.sv
`timescale 1ns/10ps

module store_queue
  import lsq_cfg_pkg::*;
  import lsq_port_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      alloc,
  input  store_exec_t               store_exec,
  input  logic                      retire_store,
  input  logic                      cache_wr_ready,
  input  lsq_idx_t                  fwd_limit,
  input  logic      [addr_w-1:0]    fwd_addr,
  output lsq_idx_t                  tail,
  output lsq_idx_t                  head,
  output logic                      full,
  output sq_entry_t [lsq_depth-1:0] entries,
  output logic                      fwd_hit,
  output logic      [data_w-1:0]    fwd_data,
  output cache_wr_req_t             cache_wr_req,
  output logic                      store_retired
);

  // Head only moves once the cache has taken the write
  assign store_retired = retire_store & cache_wr_ready;

  queue_ptrs u_ptrs (
    .clock   (clock),
    .reset   (reset),
    .alloc   (alloc),
    .dealloc (store_retired),
    .head    (head),
    .tail    (tail),
    .full    (full)
  );

  // Oldest store goes to the cache while the retire pulse is up
  always_comb begin
    cache_wr_req.wr_en = retire_store;
    cache_wr_req.addr  = entries[head].addr;
    cache_wr_req.data  = entries[head].data;
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      entries[tail].addr_valid <= 1'b0;
    end
    // Execute
    if (store_exec.valid) begin
      entries[store_exec.sq_idx].addr_valid <= 1'b1;
      entries[store_exec.sq_idx].addr       <= store_exec.addr;
      entries[store_exec.sq_idx].data       <= store_exec.data;
    end
  end

  store_forward u_fwd (
    .entries (entries),
    .head    (head),
    .limit   (fwd_limit),
    .addr    (fwd_addr),
    .hit     (fwd_hit),
    .data    (fwd_data)
  );

endmodule

// File: hw/store_forward.sv
`timescale 1ns/10ps

module store_forward
  import lsq_cfg_pkg::*;
(
  input  sq_entry_t [lsq_depth-1:0] entries,
  input  lsq_idx_t                  head,
  input  lsq_idx_t                  limit,
  input  logic      [addr_w-1:0]    addr,
  output logic                      hit,
  output logic      [data_w-1:0]    data
);

  // Scan backward from the slot just below limit toward the head.
  // The first match found is the youngest store older than the load.
  always_comb begin
    lsq_idx_t span;
    lsq_idx_t idx;

    hit  = 1'b0;
    data = '0;
    span = limit - head;

    for (int j = 1; j < lsq_depth; j++) begin
      idx = limit - lsq_idx_t'(j);
      // Only slots whose distance from head is below the snapshot count
      if (!hit && (j <= int'(span)) && entries[idx].addr_valid &&
          (entries[idx].addr == addr)) begin
        hit  = 1'b1;
        data = entries[idx].data;
      end
    end
  end

endmodule

// File: hw/queue_ptrs.sv
`timescale 1ns/10ps

module queue_ptrs
  import lsq_cfg_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     alloc,
  input  logic     dealloc,
  output lsq_idx_t head,
  output lsq_idx_t tail,
  output logic     full
);

  lsq_idx_t head_next;
  lsq_idx_t tail_next;

  // Indices wrap naturally at the power-of-two depth
  assign head_next = head + lsq_idx_t'(1);
  assign tail_next = tail + lsq_idx_t'(1);

  // One slot stays empty, so head == tail means empty
  assign full = (tail_next == head);

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (alloc) begin
        tail <= tail_next;
      end
      if (dealloc) begin
        head <= head_next;
      end
    end
  end

endmodule

// File: hw/lsq_port_pkg.sv
package lsq_port_pkg;

  import lsq_cfg_pkg::*;

  // Instruction offered at dispatch
  typedef struct packed {
    logic              valid;
    mem_op_e           op;
    logic [addr_w-1:0] pc;
  } dispatch_t;

  // Address unit outputs
  typedef struct packed {
    logic              valid;
    lsq_idx_t          sq_idx;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } store_exec_t;

  typedef struct packed {
    logic              valid;
    lsq_idx_t          lq_idx;
    logic [addr_w-1:0] addr;
  } load_exec_t;

  // Data cache side
  typedef struct packed {
    logic              rd_en;
    logic [addr_w-1:0] addr;
  } cache_rd_req_t;

  typedef struct packed {
    logic              valid;
    logic [data_w-1:0] data;
  } cache_rd_rsp_t;

  typedef struct packed {
    logic              wr_en;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } cache_wr_req_t;

  // Results back to the core
  typedef struct packed {
    logic              valid;
    lsq_idx_t          lq_idx;
    logic [data_w-1:0] data;
    logic              forwarded;
  } load_result_t;

  typedef struct packed {
    logic              valid;
    lsq_idx_t          lq_idx;
    logic [addr_w-1:0] pc;
  } violation_t;

endpackage

// File: hw/lsq_cfg_pkg.sv
package lsq_cfg_pkg;

  // Slots per queue, one always kept free to tell full from empty
  localparam int lsq_depth = 8;
  localparam int lsq_idx_w = $clog2(lsq_depth);

  localparam int addr_w = 32;
  localparam int data_w = 64;

  typedef logic [lsq_idx_w-1:0] lsq_idx_t;

  // Memory operation carried by a dispatched instruction
  typedef enum logic [1:0] {
    mem_none  = 2'd0,
    mem_load  = 2'd1,
    mem_store = 2'd2
  } mem_op_e;

  // Store queue slot
  typedef struct packed {
    logic              addr_valid;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } sq_entry_t;

  // Load queue slot
  // sq_snap is the store tail seen when the load dispatched, so every store
  // between the store head and sq_snap is older than the load
  typedef struct packed {
    logic              done;
    logic [addr_w-1:0] addr;
    logic [addr_w-1:0] pc;
    lsq_idx_t          sq_snap;
  } lq_entry_t;

endpackage
